//--- kbd_pkg.sv
package kbd_pkg;

   // Byte received from the keyboard
   typedef logic [7:0] scan_code_t;

   // Single ASCII character
   typedef logic [7:0] ascii_t;

   // Wrapping count of key presses
   typedef logic [7:0] press_count_t;

   // One decoded key event
   typedef struct packed {
      ascii_t ascii;
      logic   pressed;
      logic   released;
   } key_event_t;

   // PS/2 receiver states
   typedef enum logic [1:0] {
      st_idle,
      st_data,
      st_parity,
      st_stop
   } rx_state_t;

   // Set-2 prefix codes
   localparam scan_code_t code_break    = 8'hF0;
   localparam scan_code_t code_extended = 8'hE0;

   // Set-2 shift keys
   localparam scan_code_t code_lshift = 8'h12;
   localparam scan_code_t code_rshift = 8'h59;

endpackage

//--- ps2_rx.sv
`timescale 1ns/100ps

module ps2_rx import kbd_pkg::*; (
   input  logic       CLOCK_50,
   input  logic       rst,
   input  logic       ps2_clk,
   input  logic       ps2_dat,
   input  logic       expired,
   output logic       byte_valid,
   output scan_code_t rx_byte,
   output logic       frame_busy,
   output logic       clk_fall
);

   // Two-flop synchronizers for both lines
   logic clk_meta;
   logic clk_sync;
   logic dat_meta;
   logic dat_sync;

   // Previous synchronized clock level
   logic clk_prev;

   rx_state_t  state;
   logic [2:0] bit_cnt;
   scan_code_t shift_reg;
   logic       parity_acc;
   logic       parity_ok;

   // Lines idle high, so reset to 1 to avoid a false edge
   always_ff @(posedge CLOCK_50) begin
      if (rst) begin
         clk_meta <= 1'b1;
         clk_sync <= 1'b1;
         dat_meta <= 1'b1;
         dat_sync <= 1'b1;
         clk_prev <= 1'b1;
         clk_fall <= 1'b0;
      end else begin
         clk_meta <= ps2_clk;
         clk_sync <= clk_meta;
         dat_meta <= ps2_dat;
         dat_sync <= dat_meta;
         clk_prev <= clk_sync;
         clk_fall <= clk_prev & ~clk_sync;
      end
   end

   assign frame_busy = (state != st_idle);

   always_ff @(posedge CLOCK_50) begin
      if (rst) begin
         state      <= st_idle;
         bit_cnt    <= '0;
         parity_acc <= 1'b0;
         parity_ok  <= 1'b0;
         byte_valid <= 1'b0;
      end else begin
         byte_valid <= 1'b0;
         if (expired) begin
            // Stalled frame, drop the partial byte
            state <= st_idle;
         end else if (clk_fall) begin
            case (state)
               st_idle: begin
                  if (!dat_sync) begin
                     state      <= st_data;
                     bit_cnt    <= '0;
                     parity_acc <= 1'b0;
                  end
               end
               st_data: begin
                  // LSB first
                  shift_reg  <= {dat_sync, shift_reg[7:1]};
                  parity_acc <= parity_acc ^ dat_sync;
                  bit_cnt    <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'd7) begin
                     state <= st_parity;
                  end
               end
               st_parity: begin
                  // Odd parity over data plus parity bit
                  parity_ok <= parity_acc ^ dat_sync;
                  state     <= st_stop;
               end
               st_stop: begin
                  if (dat_sync && parity_ok) begin
                     byte_valid <= 1'b1;
                     rx_byte    <= shift_reg;
                  end
                  state <= st_idle;
               end
               default: state <= st_idle;
            endcase
         end
      end
   end

endmodule

//--- frame_watchdog.sv
`timescale 1ns/100ps

module frame_watchdog #(
   parameter int TIMEOUT_CYCLES = 50000
) (
   input  logic CLOCK_50,
   input  logic rst,
   input  logic frame_busy,
   input  logic clk_fall,
   output logic expired
);

   localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

   logic [CNT_W-1:0] idle_cnt;

   // Idle cycles since the last PS/2 clock edge of the current frame
   always_ff @(posedge CLOCK_50) begin
      if (rst) begin
         idle_cnt <= '0;
         expired  <= 1'b0;
      end else begin
         expired <= 1'b0;
         if (!frame_busy || clk_fall) begin
            idle_cnt <= '0;
         end else if (idle_cnt == CNT_W'(TIMEOUT_CYCLES - 1)) begin
            // Single pulse, then start over
            idle_cnt <= '0;
            expired  <= 1'b1;
         end else begin
            idle_cnt <= idle_cnt + 1'b1;
         end
      end
   end

endmodule

//--- scan_decoder.sv
`timescale 1ns/100ps

module scan_decoder import kbd_pkg::*; (
   input  logic       CLOCK_50,
   input  logic       rst,
   input  logic       byte_valid,
   input  scan_code_t rx_byte,
   output key_event_t key_event
);

   logic   break_pending;
   logic   ext_pending;
   logic   lshift;
   logic   rshift;
   ascii_t base_ascii;
   ascii_t shifted_ascii;

   // Set-2 make code to lower case ASCII, zero when unmapped
   function automatic ascii_t code_to_ascii(input scan_code_t code);
      ascii_t result;
      case (code)
         8'h1C: result = "a";
         8'h32: result = "b";
         8'h21: result = "c";
         8'h23: result = "d";
         8'h24: result = "e";
         8'h2B: result = "f";
         8'h34: result = "g";
         8'h33: result = "h";
         8'h43: result = "i";
         8'h3B: result = "j";
         8'h42: result = "k";
         8'h4B: result = "l";
         8'h3A: result = "m";
         8'h31: result = "n";
         8'h44: result = "o";
         8'h4D: result = "p";
         8'h15: result = "q";
         8'h2D: result = "r";
         8'h1B: result = "s";
         8'h2C: result = "t";
         8'h3C: result = "u";
         8'h2A: result = "v";
         8'h1D: result = "w";
         8'h22: result = "x";
         8'h35: result = "y";
         8'h1A: result = "z";
         8'h45: result = "0";
         8'h16: result = "1";
         8'h1E: result = "2";
         8'h26: result = "3";
         8'h25: result = "4";
         8'h2E: result = "5";
         8'h36: result = "6";
         8'h3D: result = "7";
         8'h3E: result = "8";
         8'h46: result = "9";
         8'h29: result = " ";
         8'h5A: result = 8'h0D;
         default: result = 8'h00;
      endcase
      return result;
   endfunction

   assign base_ascii = code_to_ascii(rx_byte);

   // Shift only affects letters
   always_comb begin
      shifted_ascii = base_ascii;
      if ((lshift || rshift) && base_ascii >= "a" && base_ascii <= "z") begin
         shifted_ascii = base_ascii - 8'd32;
      end
   end

   always_ff @(posedge CLOCK_50) begin
      if (rst) begin
         break_pending      <= 1'b0;
         ext_pending        <= 1'b0;
         lshift             <= 1'b0;
         rshift             <= 1'b0;
         key_event.pressed  <= 1'b0;
         key_event.released <= 1'b0;
      end else begin
         key_event.pressed  <= 1'b0;
         key_event.released <= 1'b0;
         if (byte_valid) begin
            if (rx_byte == code_break) begin
               break_pending <= 1'b1;
            end else if (rx_byte == code_extended) begin
               ext_pending <= 1'b1;
            end else begin
               break_pending <= 1'b0;
               ext_pending   <= 1'b0;
               if (break_pending && !ext_pending) begin
                  if (rx_byte == code_lshift) lshift <= 1'b0;
                  if (rx_byte == code_rshift) rshift <= 1'b0;
                  key_event.released <= 1'b1;
                  key_event.ascii    <= shifted_ascii;
               end else if (!break_pending && !ext_pending) begin
                  if (rx_byte == code_lshift) begin
                     lshift <= 1'b1;
                  end else if (rx_byte == code_rshift) begin
                     rshift <= 1'b1;
                  end else if (base_ascii != 8'h00) begin
                     key_event.pressed <= 1'b1;
                     key_event.ascii   <= shifted_ascii;
                  end
               end
            end
         end
      end
   end

endmodule

//--- console_port.sv
`timescale 1ns/100ps

module console_port import kbd_pkg::*; (
   input  logic         CLOCK_50,
   input  logic         rst,
   input  key_event_t   key_event,
   output logic         console_write,
   output logic [31:0]  console_writedata,
   output ascii_t       ledg,
   output press_count_t ledr
);

   // Write strobe, last character and press count
   always_ff @(posedge CLOCK_50) begin
      if (rst) begin
         console_write <= 1'b0;
         ledg          <= '0;
         ledr          <= '0;
      end else begin
         console_write <= key_event.pressed;
         if (key_event.pressed) begin
            ledg <= key_event.ascii;
            ledr <= ledr + 1'b1;
         end
      end
   end

   // Zero-extended character for the console data register
   always_ff @(posedge CLOCK_50) begin
      if (key_event.pressed) begin
         console_writedata <= {{(32 - $bits(ascii_t)){1'b0}}, key_event.ascii};
      end
   end

endmodule

//--- kbd_console_top.sv
`timescale 1ns/100ps

module kbd_console_top import kbd_pkg::*; #(
   parameter int TIMEOUT_CYCLES = 50000
) (
   input  logic         CLOCK_50,
   input  logic         rst,
   input  logic         ps2_clk,
   input  logic         ps2_dat,
   output logic         console_write,
   output logic [31:0]  console_writedata,
   output ascii_t       ledg,
   output press_count_t ledr
);

   logic       byte_valid;
   scan_code_t rx_byte;
   logic       frame_busy;
   logic       clk_fall;
   logic       expired;
   key_event_t key_event;

   // Keyboard frame receiver
   ps2_rx ps2_rx_i (
      .CLOCK_50   (CLOCK_50),
      .rst        (rst),
      .ps2_clk    (ps2_clk),
      .ps2_dat    (ps2_dat),
      .expired    (expired),
      .byte_valid (byte_valid),
      .rx_byte    (rx_byte),
      .frame_busy (frame_busy),
      .clk_fall   (clk_fall)
   );

   frame_watchdog #(
      .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
   ) frame_watchdog_i (
      .CLOCK_50   (CLOCK_50),
      .rst        (rst),
      .frame_busy (frame_busy),
      .clk_fall   (clk_fall),
      .expired    (expired)
   );

   scan_decoder scan_decoder_i (
      .CLOCK_50   (CLOCK_50),
      .rst        (rst),
      .byte_valid (byte_valid),
      .rx_byte    (rx_byte),
      .key_event  (key_event)
   );

   // Console write port and LEDs
   console_port console_port_i (
      .CLOCK_50          (CLOCK_50),
      .rst               (rst),
      .key_event         (key_event),
      .console_write     (console_write),
      .console_writedata (console_writedata),
      .ledg              (ledg),
      .ledr              (ledr)
   );

endmodule

//--- clk_gen.sv
`timescale 1ns/100ps

module clk_gen (
   output logic clk
);

   // 50 MHz system clock, 20 ns period
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

endmodule

//--- tb_kbd_console.sv
`timescale 1ns/100ps

module tb_kbd_console
   import kbd_pkg::*;
();

   localparam int TIMEOUT_CYCLES = 200;
   localparam int RESET_CYCLES   = 10;
   localparam int HALF_PERIOD    = 10;

   logic         CLOCK_50;
   logic         rst;
   logic         ps2_clk;
   logic         ps2_dat;
   logic         console_write;
   logic [31:0]  console_writedata;
   ascii_t       ledg;
   press_count_t ledr;

   // Trace contents, one entry per line
   string        names[$];
   string        kinds[$];
   scan_code_t   codes[$];
   string        results[$];

   press_count_t presses;
   int           cycle_limit = 0;
   int           cycle_cnt = 0;

   clk_gen clk_gen_i (
      .clk (CLOCK_50)
   );

   kbd_console_top #(
      .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
   ) kbd_console_top_i (
      .CLOCK_50          (CLOCK_50),
      .rst               (rst),
      .ps2_clk           (ps2_clk),
      .ps2_dat           (ps2_dat),
      .console_write     (console_write),
      .console_writedata (console_writedata),
      .ledg              (ledg),
      .ledr              (ledr)
   );

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("tests failed");
      $fatal(1);
   endtask

   // Step to 2 ns past a rising edge
   task automatic next_cycle(input int n);
      repeat (n) @(posedge CLOCK_50);
      #2;
   endtask

   task automatic check_ascii(input string name, input ascii_t expected);
      if (console_writedata !== {24'h0, expected}) begin
         fail_run($sformatf("ERROR %s: console_writedata expected %08h, actual %08h",
                            name, {24'h0, expected}, console_writedata));
      end
      if (ledg !== expected) begin
         fail_run($sformatf("ERROR %s: ledg expected %02h, actual %02h",
                            name, expected, ledg));
      end
   endtask

   task automatic check_count(input string name, input press_count_t expected);
      if (ledr !== expected) begin
         fail_run($sformatf("ERROR %s: ledr expected %0d, actual %0d",
                            name, expected, ledr));
      end
   endtask

   // Bit-bang one frame
   // ps2_clk stays low after the last falling edge
   task automatic send_frame(input scan_code_t code, input string kind);
      logic [10:0] bits;
      int          nbits;
      bits  = {1'b1, ~^code, code, 1'b0};
      nbits = 11;
      if (kind == "badpar") bits[9] = ^code;
      // Start bit plus four data bits
      if (kind == "trunc") nbits = 5;
      for (int i = 0; i < nbits; i++) begin
         ps2_dat = bits[i];
         next_cycle(HALF_PERIOD);
         ps2_clk = 1'b0;
         if (i < nbits - 1) begin
            next_cycle(HALF_PERIOD);
            ps2_clk = 1'b1;
         end
      end
   endtask

   task automatic run_line(input int idx);
      int     seen;
      ascii_t expected;
      seen = 0;
      send_frame(codes[idx], kinds[idx]);
      // Let the watchdog abandon the partial frame
      if (kinds[idx] == "trunc") next_cycle(TIMEOUT_CYCLES + 50);
      if (results[idx] == "--") begin
         for (int c = 0; c < 30; c++) begin
            next_cycle(1);
            if (console_write) begin
               fail_run($sformatf("Test %s: console write occurred where none was expected",
                                  names[idx]));
            end
         end
         check_count(names[idx], presses);
      end else begin
         void'($sscanf(results[idx], "%h", expected));
         for (int c = 0; c < 20 && seen == 0; c++) begin
            next_cycle(1);
            if (console_write) seen = 1;
         end
         if (seen == 0) begin
            fail_run($sformatf("Test %s: no console write within 20 cycles", names[idx]));
         end
         presses = presses + 8'd1;
         check_ascii(names[idx], expected);
         check_count(names[idx], presses);
      end
      ps2_clk = 1'b1;
      ps2_dat = 1'b1;
   endtask

   // Run limit from the trace length
   always @(posedge CLOCK_50) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
         fail_run("Timeout: the run exceeded its cycle limit");
      end
   end

   initial begin
      int         fd;
      int         gap;
      string      line;
      string      name;
      string      kind;
      string      result;
      scan_code_t code;
      rst     = 1'b1;
      ps2_clk = 1'b1;
      ps2_dat = 1'b1;
      presses = '0;
      void'($urandom(32'h9bc1));
      fd = $fopen("kbd_trace.txt", "r");
      if (fd == 0) fail_run("Cannot open kbd_trace.txt");
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 1 && line[0] != "#" &&
             $sscanf(line, "%s %s %h %s", name, kind, code, result) == 4) begin
            names.push_back(name);
            kinds.push_back(kind);
            codes.push_back(code);
            results.push_back(result);
         end
      end
      $fclose(fd);
      if (names.size() == 0) fail_run("The trace file holds no tests");
      cycle_limit = 600 * names.size() + RESET_CYCLES;

      next_cycle(RESET_CYCLES);
      rst = 1'b0;
      foreach (names[i]) begin
         gap = $urandom_range(40, 0);
         next_cycle(gap + 1);
         run_line(i);
      end
      $display("all tests passed");
      $finish;
   end

endmodule

//--- kbd_trace.txt
# Columns: test name, frame kind, scan code (hex), expected ASCII (hex) or -- for no write
# Frame kinds: good, badpar (parity bit flipped), trunc (cut after four data bits)
make_a          good   1C 61
make_1          good   16 31
make_space      good   29 20
make_enter      good   5A 0D
break_a_f0      good   F0 --
break_a         good   1C --
lshift_make     good   12 --
lshift_b        good   32 42
lshift_digit    good   1E 32
lshift_brk_f0   good   F0 --
lshift_brk      good   12 --
lower_b         good   32 62
rshift_make     good   59 --
rshift_z        good   1A 5A
rshift_brk_f0   good   F0 --
rshift_brk      good   59 --
lower_z         good   1A 7A
bad_parity      badpar 24 --
after_bad_par   good   24 65
truncated       trunc  2B --
after_trunc     good   2B 66
ext_a_e0        good   E0 --
ext_a           good   1C --
ext_shift_e0    good   E0 --
ext_shift       good   12 --
unmapped        good   76 --
still_lower     good   33 68

//--- build.f
kbd_pkg.sv
ps2_rx.sv
frame_watchdog.sv
scan_decoder.sv
console_port.sv
kbd_console_top.sv
clk_gen.sv
tb_kbd_console.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_kbd_console -f build.f -o tb_sim

# The simulator status is not trusted, the log decides
./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -q "all tests passed" sim.log; then
   echo "Simulation PASSED"
else
   echo "Simulation FAILED"
   exit 1
fi
